// File: lsu_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths, sizes and types of the load/store unit
// Imported by every block of the LSU and by the testbench
//////////////////////////////////////////////////////////////////////

package lsu_pkg;

  // Data and address width
  localparam int unsigned XLEN = 32;

  // One byte enable per data byte
  localparam int unsigned BE_W = XLEN / 8;

  // Queue entries, also the credits held by the sender after reset
  localparam int unsigned LSU_QUEUE_DEPTH = 2;
  localparam int unsigned LSU_QUEUE_PTR_W = $clog2(LSU_QUEUE_DEPTH);
  localparam int unsigned LSU_QUEUE_CNT_W = $clog2(LSU_QUEUE_DEPTH + 1);

  // Protection regions
  localparam int unsigned PMP_NUM_REGIONS = 4;
  localparam int unsigned PMP_IDX_W       = 2;

  // Access size
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } data_type_e;

  // One protection region, covers base <= addr < limit
  typedef struct packed {
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] limit;
    logic            read;
    logic            write;
    logic            enable;
  } pmp_region_t;

endpackage

// File: lsu_req_if.sv
//////////////////////////////////////////////////////////////////////
// Head of the request queue as seen by the bus controller
// Queue side drives the request, controller side answers with pop
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface lsu_req_if;

  import lsu_pkg::*;

  logic            valid;
  logic            we;
  data_type_e      dtype;
  logic            sign_ext;
  logic [XLEN-1:0] addr;
  logic [XLEN-1:0] wdata;

  // Pulsed by the controller in the cycle it takes the head
  logic            pop;

  modport queue_mp (
    output valid,
    output we,
    output dtype,
    output sign_ext,
    output addr,
    output wdata,
    input  pop
  );

  modport ctrl_mp (
    input  valid,
    input  we,
    input  dtype,
    input  sign_ext,
    input  addr,
    input  wdata,
    output pop
  );

endinterface

// File: lsu_req_queue.sv
//////////////////////////////////////////////////////////////////////
// Request FIFO at the LSU entry, filled under credit flow control
// Returns one credit pulse for every entry the controller pops
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_req_queue (
  input  logic                      clk,
  input  logic                      rst_ni,

  input  logic                      req_valid_i,
  input  logic                      req_we_i,
  input  lsu_pkg::data_type_e       req_type_i,
  input  logic                      req_sign_ext_i,
  input  logic [lsu_pkg::XLEN-1:0]  req_addr_i,
  input  logic [lsu_pkg::XLEN-1:0]  req_wdata_i,
  output logic                      credit_o,

  lsu_req_if.queue_mp               q
);

  import lsu_pkg::*;

  // Entry storage
  logic            we_mem       [LSU_QUEUE_DEPTH];
  data_type_e      dtype_mem    [LSU_QUEUE_DEPTH];
  logic            sign_ext_mem [LSU_QUEUE_DEPTH];
  logic [XLEN-1:0] addr_mem     [LSU_QUEUE_DEPTH];
  logic [XLEN-1:0] wdata_mem    [LSU_QUEUE_DEPTH];

  logic [LSU_QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [LSU_QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [LSU_QUEUE_CNT_W-1:0] count_q;
  logic                       credit_q;

  // Circular pointer advance
  function automatic logic [LSU_QUEUE_PTR_W-1:0] next_ptr(
    input logic [LSU_QUEUE_PTR_W-1:0] ptr
  );
    if (ptr == LSU_QUEUE_PTR_W'(LSU_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (q.pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q  <= count_q + LSU_QUEUE_CNT_W'(req_valid_i) - LSU_QUEUE_CNT_W'(q.pop);
      credit_q <= q.pop;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      we_mem[wr_ptr_q]       <= req_we_i;
      dtype_mem[wr_ptr_q]    <= req_type_i;
      sign_ext_mem[wr_ptr_q] <= req_sign_ext_i;
      addr_mem[wr_ptr_q]     <= req_addr_i;
      wdata_mem[wr_ptr_q]    <= req_wdata_i;
    end
  end

  // Head of queue
  assign q.valid    = (count_q != '0);
  assign q.we       = we_mem[rd_ptr_q];
  assign q.dtype    = dtype_mem[rd_ptr_q];
  assign q.sign_ext = sign_ext_mem[rd_ptr_q];
  assign q.addr     = addr_mem[rd_ptr_q];
  assign q.wdata    = wdata_mem[rd_ptr_q];

  assign credit_o = credit_q;

  // Sender spent a credit it did not hold
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_ni)
    req_valid_i |-> count_q != LSU_QUEUE_CNT_W'(LSU_QUEUE_DEPTH));

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_ni)
    q.pop |-> count_q != '0);

endmodule

// File: lsu_region_check.sv
//////////////////////////////////////////////////////////////////////
// Region protection for data accesses
// Regions are written one at a time over the config port; the check
// itself is combinational on the address and direction presented
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_region_check (
  input  logic                          clk,
  input  logic                          rst_ni,

  // Configuration write port
  input  logic                          cfg_we_i,
  input  logic [lsu_pkg::PMP_IDX_W-1:0] cfg_idx_i,
  input  lsu_pkg::pmp_region_t          cfg_region_i,

  // Access check
  input  logic [lsu_pkg::XLEN-1:0]      chk_addr_i,
  input  logic                          chk_we_i,
  output logic                          deny_o
);

  import lsu_pkg::*;

  pmp_region_t                regions_q [PMP_NUM_REGIONS];
  logic [PMP_NUM_REGIONS-1:0] region_ok;

  //////////////////////////////////////////////////////////////////////
  // Region registers
  //////////////////////////////////////////////////////////////////////

  // All regions come out of reset disabled, so everything is denied
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
        regions_q[i] <= '0;
      end
    end else if (cfg_we_i) begin
      regions_q[cfg_idx_i] <= cfg_region_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Access check
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      region_ok[i] = regions_q[i].enable &&
                     (chk_addr_i >= regions_q[i].base) &&
                     (chk_addr_i <  regions_q[i].limit) &&
                     (chk_we_i ? regions_q[i].write : regions_q[i].read);
    end
  end

  // One permitting region is enough
  assign deny_o = ~|region_ok;

endmodule

// File: lsu_bus_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Data bus controller of the LSU
// Takes requests from the queue head, runs them on the req/gnt/rvalid
// bus one at a time and returns an in-order response pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_bus_ctrl (
  input  logic                      clk,
  input  logic                      rst_ni,

  lsu_req_if.ctrl_mp                q,

  // Region check of the queue head
  output logic [lsu_pkg::XLEN-1:0]  chk_addr_o,
  output logic                      chk_we_o,
  input  logic                      deny_i,

  // Data memory bus
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  output logic                      data_we_o,
  output logic [lsu_pkg::BE_W-1:0]  data_be_o,
  output logic [lsu_pkg::XLEN-1:0]  data_addr_o,
  output logic [lsu_pkg::XLEN-1:0]  data_wdata_o,
  input  logic [lsu_pkg::XLEN-1:0]  data_rdata_i,
  input  logic                      data_err_i,

  // Response
  output logic                      rsp_valid_o,
  output logic [lsu_pkg::XLEN-1:0]  rsp_rdata_o,
  output logic                      rsp_err_o
);

  import lsu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID
  } ctrl_state_e;

  ctrl_state_e     state_q;
  logic            misaligned;

  // Request taken from the queue
  logic            we_q;
  data_type_e      dtype_q;
  logic            sign_ext_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;

  logic            rsp_valid_q;
  logic            rsp_err_q;
  logic [XLEN-1:0] rsp_rdata_q;

  logic [XLEN-1:0] rdata_shift;
  logic [XLEN-1:0] load_ext;

  //////////////////////////////////////////////////////////////////////
  // Pop and pre-bus checks
  //////////////////////////////////////////////////////////////////////

  // Misaligned accesses are not split, they fail
  assign misaligned = ((q.dtype == HALF) && q.addr[0]) ||
                      ((q.dtype == WORD) && (q.addr[1:0] != 2'b00));

  assign q.pop      = (state_q == IDLE) && q.valid;
  assign chk_addr_o = q.addr;
  assign chk_we_o   = q.we;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      unique case (state_q)
        IDLE: begin
          if (q.pop) begin
            if (misaligned || deny_i) begin
              // Fail without touching the bus
              rsp_valid_q <= 1'b1;
              rsp_err_q   <= 1'b1;
            end else begin
              state_q <= WAIT_GNT;
            end
          end
        end
        WAIT_GNT: begin
          if (data_gnt_i) begin
            state_q <= WAIT_RVALID;
          end
        end
        WAIT_RVALID: begin
          if (data_rvalid_i) begin
            state_q     <= IDLE;
            rsp_valid_q <= 1'b1;
            rsp_err_q   <= data_err_i;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (q.pop) begin
      we_q        <= q.we;
      dtype_q     <= q.dtype;
      sign_ext_q  <= q.sign_ext;
      addr_q      <= q.addr;
      wdata_q     <= q.wdata;
      rsp_rdata_q <= '0;
    end else if ((state_q == WAIT_RVALID) && data_rvalid_i) begin
      rsp_rdata_q <= (we_q || data_err_i) ? '0 : load_ext;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus side: lanes and byte enables
  //////////////////////////////////////////////////////////////////////

  assign data_req_o  = (state_q == WAIT_GNT);
  assign data_we_o   = we_q;
  assign data_addr_o = {addr_q[XLEN-1:2], 2'b00};

  always_comb begin
    unique case (dtype_q)
      WORD:    data_be_o = {BE_W{1'b1}};
      HALF:    data_be_o = addr_q[1] ? 4'b1100 : 4'b0011;
      BYTE:    data_be_o = BE_W'(1) << addr_q[1:0];
      default: data_be_o = '0;
    endcase
  end

  // Replicate so every lane the enables may pick holds the data
  always_comb begin
    unique case (dtype_q)
      HALF:    data_wdata_o = {2{wdata_q[15:0]}};
      BYTE:    data_wdata_o = {4{wdata_q[7:0]}};
      default: data_wdata_o = wdata_q;
    endcase
  end

  // Addressed byte or half moved down to bit 0, then extended
  assign rdata_shift = data_rdata_i >> {addr_q[1:0], 3'b000};

  always_comb begin
    unique case (dtype_q)
      HALF:    load_ext = {{(XLEN-16){sign_ext_q & rdata_shift[15]}}, rdata_shift[15:0]};
      BYTE:    load_ext = {{(XLEN-8){sign_ext_q & rdata_shift[7]}}, rdata_shift[7:0]};
      default: load_ext = data_rdata_i;
    endcase
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_err_q;
  assign rsp_rdata_o = rsp_rdata_q;

  // Bus request held unchanged until the memory grants it
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o &&
      $stable({data_we_o, data_be_o, data_addr_o, data_wdata_o}));

  // Memory answers only an access that was granted
  a_no_rvalid_idle: assert property (@(posedge clk) disable iff (!rst_ni)
    data_rvalid_i |-> state_q != IDLE);

endmodule

// File: lsu_top.sv
//////////////////////////////////////////////////////////////////////
// Standalone load/store unit with region protection
// Credit-based request entry, req/gnt/rvalid data bus, in-order replies
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_top (
  input  logic                          clk,
  input  logic                          rst_ni,

  // Request entry, one credit per pulse
  input  logic                          req_valid_i,
  input  logic                          req_we_i,
  input  lsu_pkg::data_type_e           req_type_i,
  input  logic                          req_sign_ext_i,
  input  logic [lsu_pkg::XLEN-1:0]      req_addr_i,
  input  logic [lsu_pkg::XLEN-1:0]      req_wdata_i,
  output logic                          credit_o,

  // Region configuration
  input  logic                          cfg_we_i,
  input  logic [lsu_pkg::PMP_IDX_W-1:0] cfg_idx_i,
  input  lsu_pkg::pmp_region_t          cfg_region_i,

  // Data memory bus
  output logic                          data_req_o,
  input  logic                          data_gnt_i,
  input  logic                          data_rvalid_i,
  output logic                          data_we_o,
  output logic [lsu_pkg::BE_W-1:0]      data_be_o,
  output logic [lsu_pkg::XLEN-1:0]      data_addr_o,
  output logic [lsu_pkg::XLEN-1:0]      data_wdata_o,
  input  logic [lsu_pkg::XLEN-1:0]      data_rdata_i,
  input  logic                          data_err_i,

  // Response
  output logic                          rsp_valid_o,
  output logic [lsu_pkg::XLEN-1:0]      rsp_rdata_o,
  output logic                          rsp_err_o
);

  lsu_req_if req_if ();

  logic [lsu_pkg::XLEN-1:0] chk_addr;
  logic                     chk_we;
  logic                     chk_deny;

  lsu_req_queue req_queue_inst (
    .clk            ( clk            ),
    .rst_ni         ( rst_ni         ),
    .req_valid_i    ( req_valid_i    ),
    .req_we_i       ( req_we_i       ),
    .req_type_i     ( req_type_i     ),
    .req_sign_ext_i ( req_sign_ext_i ),
    .req_addr_i     ( req_addr_i     ),
    .req_wdata_i    ( req_wdata_i    ),
    .credit_o       ( credit_o       ),
    .q              ( req_if         )
  );

  lsu_region_check region_check_inst (
    .clk          ( clk          ),
    .rst_ni       ( rst_ni       ),
    .cfg_we_i     ( cfg_we_i     ),
    .cfg_idx_i    ( cfg_idx_i    ),
    .cfg_region_i ( cfg_region_i ),
    .chk_addr_i   ( chk_addr     ),
    .chk_we_i     ( chk_we       ),
    .deny_o       ( chk_deny     )
  );

  lsu_bus_ctrl bus_ctrl_inst (
    .clk           ( clk           ),
    .rst_ni        ( rst_ni        ),
    .q             ( req_if        ),
    .chk_addr_o    ( chk_addr      ),
    .chk_we_o      ( chk_we        ),
    .deny_i        ( chk_deny      ),
    .data_req_o    ( data_req_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_we_o     ( data_we_o     ),
    .data_be_o     ( data_be_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .data_rdata_i  ( data_rdata_i  ),
    .data_err_i    ( data_err_i    ),
    .rsp_valid_o   ( rsp_valid_o   ),
    .rsp_rdata_o   ( rsp_rdata_o   ),
    .rsp_err_o     ( rsp_err_o     )
  );

endmodule

// File: tb_lsu_top.sv
//////////////////////////////////////////////////////////////////////
// Table-driven testbench for the LSU top level
// Models the data memory, tracks credits and checks in-order replies
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_lsu_top;

  import lsu_pkg::*;

  typedef enum logic [1:0] {E_CFG, E_REQ, E_BUSERR} entry_kind_e;

  typedef struct {
    entry_kind_e          kind;
    logic                 we;
    data_type_e           dtype;
    logic                 sign;
    logic [XLEN-1:0]      addr;
    logic [XLEN-1:0]      wdata;
    logic [PMP_IDX_W-1:0] idx;
    pmp_region_t          region;
    logic                 exp_err;
    logic                 use_ref;
    logic [XLEN-1:0]      exp_data;
  } entry_t;

  typedef struct {
    logic            err;
    logic [XLEN-1:0] data;
  } rsp_t;

  typedef struct {
    logic [XLEN-1:0] addr;
    logic [BE_W-1:0] be;
    logic            we;
    logic            err;
  } bus_t;

  logic                 clk = 1'b0;
  logic                 rst_ni;
  logic                 req_valid_i;
  logic                 req_we_i;
  data_type_e           req_type_i;
  logic                 req_sign_ext_i;
  logic [XLEN-1:0]      req_addr_i;
  logic [XLEN-1:0]      req_wdata_i;
  logic                 credit_o;
  logic                 cfg_we_i;
  logic [PMP_IDX_W-1:0] cfg_idx_i;
  pmp_region_t          cfg_region_i;
  logic                 data_req_o;
  logic                 data_gnt_i;
  logic                 data_rvalid_i;
  logic                 data_we_o;
  logic [BE_W-1:0]      data_be_o;
  logic [XLEN-1:0]      data_addr_o;
  logic [XLEN-1:0]      data_wdata_o;
  logic [XLEN-1:0]      data_rdata_i;
  logic                 data_err_i;
  logic                 rsp_valid_o;
  logic [XLEN-1:0]      rsp_rdata_o;
  logic                 rsp_err_o;

  entry_t          stim_q[$];
  rsp_t            sb_q[$];
  bus_t            bus_q[$];
  logic [XLEN-1:0] mem     [128];
  logic [XLEN-1:0] ref_mem [128];
  integer          seed = 32'h98dc;
  int              credits;

  always #50 clk = ~clk;

  lsu_top lsu_top_inst (.*);

  //////////////////////////////////////////////////////////////////////
  // Reporting and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected));
    end
  endtask

  // Start contents of a word depend on the whole address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h0019_660d) ^ 32'hc3a5_5a3c;
  endfunction

  function automatic logic [BE_W-1:0] lane_mask(input data_type_e dt, input logic [1:0] off);
    case (dt)
      BYTE:    return 4'b0001 << off;
      HALF:    return 4'b0011 << off;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] word, input data_type_e dt,
                                                input logic sign, input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*off +: 8];
    h = word[8*off +: 16];
    case (dt)
      BYTE:    return sign ? {{24{b[7]}}, b} : {24'h0, b};
      HALF:    return sign ? {{16{h[15]}}, h} : {16'h0, h};
      default: return word;
    endcase
  endfunction

  // Only the addressed lanes of the reference word change
  task automatic store_ref(input logic [6:0] idx, input logic [1:0] off,
                           input data_type_e dt, input logic [31:0] wdata);
    case (dt)
      BYTE:    ref_mem[idx][8*off +: 8] = wdata[7:0];
      HALF:    ref_mem[idx][8*off +: 16] = wdata[15:0];
      default: ref_mem[idx] = wdata;
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic add_req(input logic we, input data_type_e dt, input logic sign,
                         input logic [31:0] addr, input logic [31:0] wdata,
                         input logic exp_err, input logic use_ref, input logic [31:0] exp_data);
    entry_t e;
    e.kind     = E_REQ;
    e.we       = we;
    e.dtype    = dt;
    e.sign     = sign;
    e.addr     = addr;
    e.wdata    = wdata;
    e.exp_err  = exp_err;
    e.use_ref  = use_ref;
    e.exp_data = exp_data;
    stim_q.push_back(e);
  endtask

  task automatic add_cfg(input logic [PMP_IDX_W-1:0] idx, input logic [31:0] base,
                         input logic [31:0] limit, input logic rd, input logic wr);
    entry_t e;
    e.kind          = E_CFG;
    e.idx           = idx;
    e.region.base   = base;
    e.region.limit  = limit;
    e.region.read   = rd;
    e.region.write  = wr;
    e.region.enable = 1'b1;
    stim_q.push_back(e);
  endtask

  task automatic add_bus_err();
    entry_t e;
    e.kind = E_BUSERR;
    stim_q.push_back(e);
  endtask

  task automatic build_stimulus();
    logic [31:0] r;
    logic [31:0] addr;
    data_type_e  dt;
    int unsigned word_sel;
    int          n;
    // No region enabled yet
    add_req(1'b0, WORD, 1'b0, 32'h10, 32'h0, 1'b1, 1'b0, 32'h0);
    add_req(1'b1, BYTE, 1'b0, 32'h20, 32'h55, 1'b1, 1'b0, 32'h0);
    add_cfg(2'd0, 32'h000, 32'h100, 1'b1, 1'b1);
    add_cfg(2'd1, 32'h100, 32'h140, 1'b1, 1'b0);
    // Sizes and lanes
    add_req(1'b1, WORD, 1'b0, 32'h10, 32'h8081_f2f3, 1'b0, 1'b0, 32'h0);
    add_req(1'b0, WORD, 1'b0, 32'h10, 32'h0, 1'b0, 1'b0, 32'h8081_f2f3);
    add_req(1'b1, HALF, 1'b0, 32'h12, 32'h0000_1234, 1'b0, 1'b0, 32'h0);
    add_req(1'b0, WORD, 1'b0, 32'h10, 32'h0, 1'b0, 1'b0, 32'h1234_f2f3);
    add_req(1'b1, BYTE, 1'b0, 32'h11, 32'h0000_00a5, 1'b0, 1'b0, 32'h0);
    add_req(1'b0, WORD, 1'b0, 32'h10, 32'h0, 1'b0, 1'b0, 32'h1234_a5f3);
    add_req(1'b1, BYTE, 1'b0, 32'h13, 32'h0000_009c, 1'b0, 1'b0, 32'h0);
    add_req(1'b0, WORD, 1'b0, 32'h10, 32'h0, 1'b0, 1'b0, 32'h9c34_a5f3);
    // Extension
    add_req(1'b0, BYTE, 1'b1, 32'h11, 32'h0, 1'b0, 1'b0, 32'hffff_ffa5);
    add_req(1'b0, BYTE, 1'b0, 32'h11, 32'h0, 1'b0, 1'b0, 32'h0000_00a5);
    add_req(1'b0, HALF, 1'b1, 32'h12, 32'h0, 1'b0, 1'b0, 32'hffff_9c34);
    add_req(1'b0, HALF, 1'b0, 32'h12, 32'h0, 1'b0, 1'b0, 32'h0000_9c34);
    add_req(1'b0, HALF, 1'b1, 32'h10, 32'h0, 1'b0, 1'b0, 32'hffff_a5f3);
    add_req(1'b0, BYTE, 1'b1, 32'h12, 32'h0, 1'b0, 1'b0, 32'h0000_0034);
    add_req(1'b0, BYTE, 1'b0, 32'h13, 32'h0, 1'b0, 1'b0, 32'h0000_009c);
    // Misaligned accesses leave memory as it was
    add_req(1'b0, HALF, 1'b0, 32'h11, 32'h0, 1'b1, 1'b0, 32'h0);
    add_req(1'b1, WORD, 1'b0, 32'h12, 32'h1111_1111, 1'b1, 1'b0, 32'h0);
    add_req(1'b1, HALF, 1'b0, 32'h13, 32'h2222_2222, 1'b1, 1'b0, 32'h0);
    add_req(1'b0, WORD, 1'b0, 32'h10, 32'h0, 1'b0, 1'b0, 32'h9c34_a5f3);
    add_req(1'b0, WORD, 1'b0, 32'h20, 32'h0, 1'b0, 1'b1, 32'h0);
    // Regions
    add_req(1'b0, WORD, 1'b0, 32'h200, 32'h0, 1'b1, 1'b0, 32'h0);
    add_req(1'b1, WORD, 1'b0, 32'h104, 32'h3333_3333, 1'b1, 1'b0, 32'h0);
    add_req(1'b0, WORD, 1'b0, 32'h104, 32'h0, 1'b0, 1'b1, 32'h0);
    add_req(1'b0, WORD, 1'b0, 32'h140, 32'h0, 1'b1, 1'b0, 32'h0);
    add_req(1'b1, WORD, 1'b0, 32'h0fc, 32'h1111_2222, 1'b0, 1'b0, 32'h0);
    add_req(1'b0, WORD, 1'b0, 32'h0fc, 32'h0, 1'b0, 1'b0, 32'h1111_2222);
    // Bus errors
    add_bus_err();
    add_req(1'b0, WORD, 1'b0, 32'h30, 32'h0, 1'b1, 1'b0, 32'h0);
    add_bus_err();
    add_req(1'b1, WORD, 1'b0, 32'h34, 32'hdead_beef, 1'b1, 1'b0, 32'h0);
    add_req(1'b0, WORD, 1'b0, 32'h34, 32'h0, 1'b0, 1'b1, 32'h0);
    // Back-to-back random traffic inside region 0
    for (n = 0; n < 24; n++) begin
      r        = $random(seed);
      dt       = (r[1:0] == 2'b11) ? WORD : data_type_e'(r[1:0]);
      word_sel = r[13:8] % 48;
      addr     = 32'h40 + 32'(word_sel * 4);
      if (dt == BYTE) begin
        addr[1:0] = r[15:14];
      end else if (dt == HALF) begin
        addr[1:0] = {r[15], 1'b0};
      end
      add_req(r[16], dt, r[17], addr, $random(seed), 1'b0, 1'b1, 32'h0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Driver, credit counter and response checker
  //////////////////////////////////////////////////////////////////////

  task automatic issue_request(input entry_t e, input logic bus_err);
    rsp_t       exp;
    bus_t       acc;
    logic [6:0] idx;
    logic [1:0] off;
    idx = e.addr[8:2];
    off = e.addr[1:0];
    req_valid_i    <= 1'b1;
    req_we_i       <= e.we;
    req_type_i     <= e.dtype;
    req_sign_ext_i <= e.sign;
    req_addr_i     <= e.addr;
    req_wdata_i    <= e.wdata;
    exp.err  = e.exp_err;
    exp.data = (e.use_ref && !e.we) ? expected_load(ref_mem[idx], e.dtype, e.sign, off)
                                    : e.exp_data;
    sb_q.push_back(exp);
    // Only permitted, aligned accesses reach the memory
    if (!e.exp_err || bus_err) begin
      acc.addr = {e.addr[31:2], 2'b00};
      acc.be   = lane_mask(e.dtype, off);
      acc.we   = e.we;
      acc.err  = bus_err;
      bus_q.push_back(acc);
    end
    if (e.we && !e.exp_err) begin
      store_ref(idx, off, e.dtype, e.wdata);
    end
  endtask

  task automatic check_response();
    rsp_t exp;
    if (sb_q.size() == 0) begin
      abort_run("A response arrived while no request was outstanding");
    end else begin
      exp = sb_q.pop_front();
      check_value("rsp_err_o", 32'(rsp_err_o), 32'(exp.err));
      check_value("rsp_rdata_o", rsp_rdata_o, exp.data);
    end
  endtask

  initial begin : main_flow
    entry_t      e;
    int unsigned next;
    int unsigned cycles;
    int unsigned limit;
    logic        bus_err_armed;
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_we_i       = 1'b0;
    req_type_i     = WORD;
    req_sign_ext_i = 1'b0;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    cfg_we_i       = 1'b0;
    cfg_idx_i      = '0;
    cfg_region_i   = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    data_err_i     = 1'b0;
    for (int i = 0; i < 128; i++) begin
      mem[i]     = fill_word(32'(i) << 2);
      ref_mem[i] = fill_word(32'(i) << 2);
    end
    build_stimulus();
    limit         = 20 * stim_q.size() + 5;
    credits       = int'(LSU_QUEUE_DEPTH);
    next          = 0;
    cycles        = 5;
    bus_err_armed = 1'b0;
    repeat (5) @(posedge clk);
    rst_ni <= 1'b1;
    while (next < stim_q.size() || sb_q.size() != 0 || credits != int'(LSU_QUEUE_DEPTH)) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        abort_run($sformatf("Timeout: the run did not finish within %0d cycles", limit));
      end else begin
        req_valid_i <= 1'b0;
        cfg_we_i    <= 1'b0;
        if (credit_o) begin
          credits++;
        end
        if (credits > int'(LSU_QUEUE_DEPTH)) begin
          abort_run("The credit count rose above the queue depth");
        end
        if (rsp_valid_o) begin
          check_response();
        end
        if (next < stim_q.size()) begin
          e = stim_q[next];
          case (e.kind)
            E_BUSERR: begin
              bus_err_armed = 1'b1;
              next++;
            end
            // Region writes wait until the unit has drained
            E_CFG: begin
              if (sb_q.size() == 0 && credits == int'(LSU_QUEUE_DEPTH)) begin
                cfg_we_i     <= 1'b1;
                cfg_idx_i    <= e.idx;
                cfg_region_i <= e.region;
                next++;
              end
            end
            default: begin
              if (credits != 0) begin
                issue_request(e, bus_err_armed);
                bus_err_armed = 1'b0;
                credits--;
                next++;
              end
            end
          endcase
        end
      end
    end
    if (bus_q.size() != 0) begin
      abort_run("Some expected bus accesses never reached the memory");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory model with random grant delay and rvalid one cycle later
  //////////////////////////////////////////////////////////////////////

  initial begin : memory_model
    bus_t        acc;
    int unsigned delay;
    logic [6:0]  idx;
    logic [31:0] word;
    int          b;
    forever begin
      @(posedge clk);
      if (data_req_o) begin
        if (bus_q.size() == 0) begin
          abort_run("A bus request was raised for an access that must not reach memory");
        end else begin
          acc = bus_q.pop_front();
          check_value("data_addr_o", data_addr_o, acc.addr);
          check_value("data_be_o", 32'(data_be_o), 32'(acc.be));
          check_value("data_we_o", 32'(data_we_o), 32'(acc.we));
          delay = $unsigned($random(seed)) % 4;
          repeat (delay) @(posedge clk);
          idx  = data_addr_o[8:2];
          word = mem[idx];
          if (data_we_o && !acc.err) begin
            for (b = 0; b < BE_W; b++) begin
              if (data_be_o[b]) begin
                mem[idx][8*b +: 8] = data_wdata_o[8*b +: 8];
              end
            end
          end
          data_gnt_i <= 1'b1;
          @(posedge clk);
          data_gnt_i    <= 1'b0;
          data_rvalid_i <= 1'b1;
          data_rdata_i  <= word;
          data_err_i    <= acc.err;
          @(posedge clk);
          data_rvalid_i <= 1'b0;
          data_err_i    <= 1'b0;
        end
      end
    end
  end

endmodule

// File: lsu.f
lsu_pkg.sv
lsu_req_if.sv
lsu_req_queue.sv
lsu_region_check.sv
lsu_bus_ctrl.sv
lsu_top.sv
tb_lsu_top.sv

// File: Makefile
SIM    := verilator
FLAGS  := --binary --timing --assert
TOP    := tb_lsu_top
FLIST  := lsu.f

BUILD  := obj_dir
BIN    := $(BUILD)/V$(TOP)
LOG    := sim.log
SRCS   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
